// ==== cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

    // datapath width
    localparam int data_w = 8;

    // register file size and index width
    localparam int reg_count = 8;
    localparam int reg_idx_w = 3;

    // every instruction field is one byte wide
    localparam int field_w = 8;

    // opcode byte of the instruction word
    typedef enum logic [field_w-1:0] {
        loadi  = 8'd0,
        mov    = 8'd1,
        add    = 8'd2,
        sub    = 8'd3,
        and_op = 8'd4,
        or_op  = 8'd5,
        mult   = 8'd6,
        sll    = 8'd7,
        sra    = 8'd8,
        ror    = 8'd9
    } opcode_t;

    // 32-bit instruction word
    // register fields use only their low reg_idx_w bits
    typedef struct packed {
        // [31:24]
        opcode_t              opcode;
        // [23:16]
        logic [field_w-1:0]   dest;
        // [15:8]
        logic [field_w-1:0]   src1;
        // [7:0] second source register or immediate
        logic [field_w-1:0]   src2_imm;
    } instr_t;

endpackage

`default_nettype wire

// ==== cpu_ctrl_pkg.sv ====
`default_nettype none

package cpu_ctrl_pkg;

    // alu function select codes
    typedef enum logic [2:0] {
        sel_fwd  = 3'b000,
        sel_add  = 3'b001,
        sel_and  = 3'b010,
        sel_or   = 3'b011,
        sel_mult = 3'b100,
        sel_sll  = 3'b101,
        sel_sra  = 3'b110,
        sel_ror  = 3'b111
    } alu_sel_t;

    // decoded instruction held for one execute cycle
    typedef struct packed {
        logic                                valid;
        alu_sel_t                            sel;
        // operand 2 from immediate instead of rd_data2
        logic                                use_imm;
        // two's complement of operand 2 for sub
        logic                                negate;
        // instruction is allowed to touch the zero flag
        logic                                upd_zero;
        logic [cpu_isa_pkg::reg_idx_w-1:0]   dest;
        logic [cpu_isa_pkg::reg_idx_w-1:0]   src1;
        logic [cpu_isa_pkg::reg_idx_w-1:0]   src2;
        logic [cpu_isa_pkg::data_w-1:0]      imm;
    } exec_ctrl_t;

    // alu outcome toward register file and result port
    typedef struct packed {
        logic                                valid;
        logic [cpu_isa_pkg::reg_idx_w-1:0]   dest;
        logic [cpu_isa_pkg::data_w-1:0]      data;
        logic                                upd_zero;
    } wb_t;

endpackage

`default_nettype wire

// ==== instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire cpu_isa_pkg::instr_t      instr,
    input  wire logic                     instr_valid,
    output cpu_ctrl_pkg::exec_ctrl_t      ctrl
);

    cpu_ctrl_pkg::exec_ctrl_t ctrl_next;

    // opcode to control mapping
    always_comb begin
        ctrl_next          = '0;
        // register fields keep only their low bits
        ctrl_next.dest     = instr.dest[cpu_isa_pkg::reg_idx_w-1:0];
        ctrl_next.src1     = instr.src1[cpu_isa_pkg::reg_idx_w-1:0];
        ctrl_next.src2     = instr.src2_imm[cpu_isa_pkg::reg_idx_w-1:0];
        ctrl_next.imm      = instr.src2_imm;
        ctrl_next.valid    = instr_valid;
        ctrl_next.sel      = cpu_ctrl_pkg::sel_fwd;
        case (instr.opcode)
            // forward of the immediate
            cpu_isa_pkg::loadi: begin
                ctrl_next.use_imm = 1'b1;
            end
            // forward of the register in the src2 slot
            cpu_isa_pkg::mov: begin
                ctrl_next.sel = cpu_ctrl_pkg::sel_fwd;
            end
            cpu_isa_pkg::add: begin
                ctrl_next.sel      = cpu_ctrl_pkg::sel_add;
                ctrl_next.upd_zero = 1'b1;
            end
            // sub is add with negated operand 2
            cpu_isa_pkg::sub: begin
                ctrl_next.sel      = cpu_ctrl_pkg::sel_add;
                ctrl_next.negate   = 1'b1;
                ctrl_next.upd_zero = 1'b1;
            end
            cpu_isa_pkg::and_op: ctrl_next.sel = cpu_ctrl_pkg::sel_and;
            cpu_isa_pkg::or_op:  ctrl_next.sel = cpu_ctrl_pkg::sel_or;
            cpu_isa_pkg::mult:   ctrl_next.sel = cpu_ctrl_pkg::sel_mult;
            // shifts take their amount from the immediate
            cpu_isa_pkg::sll: begin
                ctrl_next.sel     = cpu_ctrl_pkg::sel_sll;
                ctrl_next.use_imm = 1'b1;
            end
            cpu_isa_pkg::sra: begin
                ctrl_next.sel     = cpu_ctrl_pkg::sel_sra;
                ctrl_next.use_imm = 1'b1;
            end
            cpu_isa_pkg::ror: begin
                ctrl_next.sel     = cpu_ctrl_pkg::sel_ror;
                ctrl_next.use_imm = 1'b1;
            end
            // unknown opcode, dropped
            default: ctrl_next.valid = 1'b0;
        endcase
    end

    // one execute cycle per accepted instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl <= '0;
        end else begin
            ctrl <= ctrl_next;
        end
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n,
    input  wire logic [cpu_isa_pkg::reg_idx_w-1:0]    rd_addr1,
    input  wire logic [cpu_isa_pkg::reg_idx_w-1:0]    rd_addr2,
    output logic [cpu_isa_pkg::data_w-1:0]            rd_data1,
    output logic [cpu_isa_pkg::data_w-1:0]            rd_data2,
    input  wire cpu_ctrl_pkg::wb_t                    wb
);

    logic [cpu_isa_pkg::data_w-1:0] regs [cpu_isa_pkg::reg_count];

    // both read ports are plain muxes
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

    // single write port, driven by the alu outcome
    // write lands on the edge that opens the next read cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < cpu_isa_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.dest] <= wb.data;
        end
    end

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire cpu_ctrl_pkg::exec_ctrl_t             ctrl,
    input  wire logic [cpu_isa_pkg::data_w-1:0]       rd_data1,
    input  wire logic [cpu_isa_pkg::data_w-1:0]       rd_data2,
    output cpu_ctrl_pkg::wb_t                         wb,
    output logic                                      add_zero
);

    logic [cpu_isa_pkg::data_w-1:0]   op1;
    logic [cpu_isa_pkg::data_w-1:0]   op2_raw;
    logic [cpu_isa_pkg::data_w-1:0]   op2;
    logic [cpu_isa_pkg::data_w-1:0]   add_result;
    logic [2*cpu_isa_pkg::data_w-1:0] product;
    logic [2*cpu_isa_pkg::data_w-1:0] ror_wide;
    logic [cpu_isa_pkg::data_w-1:0]   result;

    // operand selection
    assign op1     = rd_data1;
    assign op2_raw = ctrl.use_imm ? ctrl.imm : rd_data2;
    // two's complement for sub
    assign op2     = ctrl.negate ? (~op2_raw + 1'b1) : op2_raw;

    // add path, also feeds the zero detect
    assign add_result = op1 + op2;
    assign add_zero   = (add_result == '0);

    // behavioural multiplier, low byte kept
    assign product = op1 * op2;

    // doubled operand, a right shift of it gives the rotate
    assign ror_wide = {op1, op1} >> op2[2:0];

    // function select
    always_comb begin
        result = '0;
        case (ctrl.sel)
            cpu_ctrl_pkg::sel_fwd:  result = op2;
            cpu_ctrl_pkg::sel_add:  result = add_result;
            cpu_ctrl_pkg::sel_and:  result = op1 & op2;
            cpu_ctrl_pkg::sel_or:   result = op1 | op2;
            cpu_ctrl_pkg::sel_mult: result = product[cpu_isa_pkg::data_w-1:0];
            cpu_ctrl_pkg::sel_sll: begin
                // everything shifted out
                if (op2 >= cpu_isa_pkg::data_w) begin
                    result = '0;
                end else begin
                    result = op1 << op2;
                end
            end
            cpu_ctrl_pkg::sel_sra: begin
                // full sign fill
                if (op2 >= cpu_isa_pkg::data_w) begin
                    result = {cpu_isa_pkg::data_w{op1[cpu_isa_pkg::data_w-1]}};
                end else begin
                    result = $signed(op1) >>> op2;
                end
            end
            // amount taken modulo 8
            cpu_ctrl_pkg::sel_ror:  result = ror_wide[cpu_isa_pkg::data_w-1:0];
            default:                result = '0;
        endcase
    end

    // outcome bundle for write port and result register
    always_comb begin
        wb.valid    = ctrl.valid;
        wb.dest     = ctrl.dest;
        wb.data     = result;
        wb.upd_zero = ctrl.upd_zero;
    end

endmodule

`default_nettype wire

// ==== result_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_writeback (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire cpu_ctrl_pkg::wb_t                 wb,
    input  wire logic                              add_zero,
    output logic [cpu_isa_pkg::data_w-1:0]         result,
    output logic [cpu_isa_pkg::reg_idx_w-1:0]      result_dest,
    output logic                                   result_valid,
    output logic                                   zero
);

    // valid pulse and sticky zero flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            zero         <= 1'b0;
        end else begin
            // one cycle per completed instruction
            result_valid <= wb.valid;
            // only add and sub move the flag
            if (wb.valid && wb.upd_zero) begin
                zero <= add_zero;
            end
        end
    end

    // result payload, held between instructions
    always_ff @(posedge clk) begin
        if (wb.valid) begin
            result      <= wb.data;
            result_dest <= wb.dest;
        end
    end

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire cpu_isa_pkg::instr_t               instr,
    input  wire logic                              instr_valid,
    output logic [cpu_isa_pkg::data_w-1:0]         result,
    output logic [cpu_isa_pkg::reg_idx_w-1:0]      result_dest,
    output logic                                   result_valid,
    output logic                                   zero
);

    cpu_ctrl_pkg::exec_ctrl_t         ctrl;
    cpu_ctrl_pkg::wb_t                wb;
    logic [cpu_isa_pkg::data_w-1:0]   rd_data1;
    logic [cpu_isa_pkg::data_w-1:0]   rd_data2;
    logic                             add_zero;

    // input side, decode stage
    instr_decode i_instr_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .ctrl        (ctrl)
    );

    // register file, read in execute, written by the alu outcome
    reg_file i_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_addr1 (ctrl.src1),
        .rd_addr2 (ctrl.src2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wb       (wb)
    );

    alu i_alu (
        .ctrl     (ctrl),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wb       (wb),
        .add_zero (add_zero)
    );

    // output side
    result_writeback i_result_writeback (
        .clk          (clk),
        .arst_n       (arst_n),
        .wb           (wb),
        .add_zero     (add_zero),
        .result       (result),
        .result_dest  (result_dest),
        .result_valid (result_valid),
        .zero         (zero)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    // 100 ns period
    localparam int half_period_ns = 50;
    localparam int reset_cycles   = 8;

    initial begin
        clk = 1'b0;
        forever begin
            #(half_period_ns) clk = ~clk;
        end
    end

    // reset held for 8 rising edges, released away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;

    localparam int clk_period_ns = 100;
    // issue slots of all six tests
    localparam int n_instr       = 78;
    // reset, start-up and per-test drain cycles
    localparam int n_overhead    = 8 + 2 + 6 * 4;

    // expected result tagged with the negedge it must show up on
    typedef struct packed {
        logic [31:0] due;
        logic [7:0]  data;
        logic [2:0]  dest;
        logic        zero;
    } expect_t;

    logic                 clk;
    logic                 arst_n;
    cpu_isa_pkg::instr_t  instr;
    logic                 instr_valid;
    logic [7:0]           result;
    logic [2:0]           result_dest;
    logic                 result_valid;
    logic                 zero;

    // reference model state
    logic [7:0]  m_regs [8] = '{default: 8'h00};
    logic        m_zero = 1'b0;
    expect_t     exp_q [$];
    expect_t     got_exp;
    int          neg_cnt = 0;
    int          err_cnt = 0;
    int          err_mark = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] lfsr_state = 32'h8900b386;

    tb_clock_gen i_tb_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    cpu_core i_cpu_core (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .result       (result),
        .result_dest  (result_dest),
        .result_valid (result_valid),
        .zero         (zero)
    );

    // galois lfsr stepped once per bit taken
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_state[0]};
            if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            else lfsr_state = lfsr_state >> 1;
        end
        return v;
    endfunction

    // shifts done one bit position at a time
    function automatic logic [7:0] shift_model(input cpu_isa_pkg::opcode_t op,
                                               input logic [7:0] a, input logic [7:0] amt);
        logic [7:0] r;
        int         steps;
        r = a;
        // rotate wraps while shifts saturate at a full byte
        if (op == cpu_isa_pkg::ror) steps = amt % 8;
        else steps = (amt > 8) ? 8 : amt;
        for (int i = 0; i < steps; i++) begin
            if (op == cpu_isa_pkg::sll) r = {r[6:0], 1'b0};
            else if (op == cpu_isa_pkg::sra) r = {r[7], r[7:1]};
            else r = {r[0], r[7:1]};
        end
        return r;
    endfunction

    task automatic value_error(input string name, input logic [7:0] exp_v,
                               input logic [7:0] act_v);
        $display("** Error at %0t: %s expected %02h got %02h", $time, name, exp_v, act_v);
        err_cnt++;
    endtask

    // drive one instruction and queue its expected outcome
    task automatic issue(input cpu_isa_pkg::opcode_t op, input logic [2:0] dest,
                         input logic [2:0] src1, input logic [7:0] src2_imm);
        cpu_isa_pkg::instr_t w;
        logic [7:0]          a;
        logic [7:0]          b;
        logic [7:0]          r;
        logic                known;
        expect_t             e;
        w.opcode   = op;
        w.dest     = {5'b0, dest};
        w.src1     = {5'b0, src1};
        w.src2_imm = src2_imm;
        a     = m_regs[src1];
        b     = m_regs[src2_imm[2:0]];
        known = 1'b1;
        case (op)
            cpu_isa_pkg::loadi:  r = src2_imm;
            cpu_isa_pkg::mov:    r = b;
            cpu_isa_pkg::add:    r = a + b;
            cpu_isa_pkg::sub:    r = a - b;
            cpu_isa_pkg::and_op: r = a & b;
            cpu_isa_pkg::or_op:  r = a | b;
            // low byte of the product
            cpu_isa_pkg::mult:   r = a * b;
            cpu_isa_pkg::sll,
            cpu_isa_pkg::sra,
            cpu_isa_pkg::ror:    r = shift_model(op, a, src2_imm);
            default: begin
                r     = '0;
                known = 1'b0;
            end
        endcase
        @(posedge clk);
        instr       <= w;
        instr_valid <= 1'b1;
        if (known) begin
            m_regs[dest] = r;
            if (op == cpu_isa_pkg::add || op == cpu_isa_pkg::sub) m_zero = (r == 8'h00);
            // dut samples on the next edge and the result is seen on the third negedge
            e.due  = neg_cnt + 3;
            e.data = r;
            e.dest = dest;
            e.zero = m_zero;
            exp_q.push_back(e);
        end
    endtask

    // stop strobing, wait for results in flight, report the test
    task automatic finish_test(input string name);
        @(posedge clk);
        instr_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        if (err_cnt == err_mark) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, err_cnt - err_mark);
            tests_failed++;
        end
        err_mark = err_cnt;
    endtask

    // outputs sampled mid-cycle on every cycle
    always @(negedge clk) begin
        neg_cnt = neg_cnt + 1;
        if (arst_n === 1'b1) begin
            if (exp_q.size() != 0 && exp_q[0].due == neg_cnt) begin
                got_exp = exp_q.pop_front();
                if (result_valid !== 1'b1) value_error("result_valid", 8'h01, {7'b0, result_valid});
                if (result !== got_exp.data) value_error("result", got_exp.data, result);
                if (result_dest !== got_exp.dest) begin
                    value_error("result_dest", {5'b0, got_exp.dest}, {5'b0, result_dest});
                end
                if (zero !== got_exp.zero) value_error("zero", {7'b0, got_exp.zero}, {7'b0, zero});
            end else if (result_valid !== 1'b0) begin
                // pulse with nothing expected or a result on the wrong cycle
                value_error("result_valid", 8'h00, {7'b0, result_valid});
            end
        end
    end

    task automatic reset_and_mov();
        if (result_valid !== 1'b0) value_error("result_valid", 8'h00, {7'b0, result_valid});
        if (zero !== 1'b0) value_error("zero", 8'h00, {7'b0, zero});
        for (int i = 0; i < 8; i++) begin
            issue(cpu_isa_pkg::mov, 3'(i), 3'(i), 8'(i));
        end
        finish_test("1 reset and mov");
    endtask

    task automatic load_all_regs();
        logic [7:0] v;
        for (int i = 0; i < 8; i++) begin
            v = take_bits(8);
            issue(cpu_isa_pkg::loadi, 3'(i), 3'd0, v);
        end
        finish_test("2 loadi");
    endtask

    task automatic alu_ops_back_to_back();
        cpu_isa_pkg::opcode_t ops [5];
        logic [2:0]           d;
        logic [2:0]           s1;
        logic [2:0]           s2;
        ops[0] = cpu_isa_pkg::add;
        ops[1] = cpu_isa_pkg::sub;
        ops[2] = cpu_isa_pkg::and_op;
        ops[3] = cpu_isa_pkg::or_op;
        ops[4] = cpu_isa_pkg::mult;
        for (int i = 0; i < 10; i++) begin
            d  = 3'(take_bits(3));
            s1 = 3'(take_bits(3));
            s2 = 3'(take_bits(3));
            issue(ops[i % 5], d, s1, {5'b0, s2});
        end
        // second reads r1 right as the first writes it
        issue(cpu_isa_pkg::add, 3'd1, 3'd2, 8'd3);
        issue(cpu_isa_pkg::sub, 3'd4, 3'd1, 8'd5);
        finish_test("3 alu ops back-to-back");
    endtask

    task automatic shift_amounts();
        logic [2:0] src;
        // one negative and one positive source for sra
        issue(cpu_isa_pkg::loadi, 3'd1, 3'd0, take_bits(8) | 8'h80);
        issue(cpu_isa_pkg::loadi, 3'd2, 3'd0, take_bits(8) & 8'h7f);
        for (int amt = 0; amt <= 10; amt++) begin
            src = (amt % 2 == 0) ? 3'd1 : 3'd2;
            issue(cpu_isa_pkg::sll, 3'd3, src, 8'(amt));
            issue(cpu_isa_pkg::sra, 3'd4, src, 8'(amt));
            issue(cpu_isa_pkg::ror, 3'd5, src, 8'(amt));
        end
        finish_test("4 shifts");
    endtask

    task automatic zero_flag_rules();
        logic [7:0] v;
        v = take_bits(8);
        issue(cpu_isa_pkg::loadi, 3'd0, 3'd0, v);
        issue(cpu_isa_pkg::loadi, 3'd1, 3'd0, v);
        // equal operands set the flag
        issue(cpu_isa_pkg::sub, 3'd2, 3'd0, 8'd1);
        // these must not touch the flag
        issue(cpu_isa_pkg::and_op, 3'd3, 3'd0, 8'd1);
        issue(cpu_isa_pkg::loadi, 3'd4, 3'd0, 8'h10);
        issue(cpu_isa_pkg::mult, 3'd5, 3'd0, 8'd4);
        // 0x20 clears the flag
        issue(cpu_isa_pkg::add, 3'd7, 3'd4, 8'd4);
        issue(cpu_isa_pkg::loadi, 3'd3, 3'd0, 8'hf0);
        // 0xf0 + 0x10 wraps to 0
        issue(cpu_isa_pkg::add, 3'd6, 3'd3, 8'd4);
        issue(cpu_isa_pkg::and_op, 3'd2, 3'd3, 8'd4);
        issue(cpu_isa_pkg::add, 3'd7, 3'd4, 8'd4);
        finish_test("5 zero flag");
    endtask

    task automatic dropped_instrs();
        cpu_isa_pkg::instr_t w;
        w          = '0;
        w.opcode   = cpu_isa_pkg::loadi;
        w.dest     = 8'd2;
        w.src2_imm = 8'h3c;
        // src2 slot selects r7 so a stray write would change r2
        issue(cpu_isa_pkg::opcode_t'(8'hff), 3'd2, 3'd0, 8'h3f);
        // valid loadi on the bus but no strobe
        @(posedge clk);
        instr       <= w;
        instr_valid <= 1'b0;
        @(posedge clk);
        instr_valid <= 1'b0;
        // r2 must still hold its old value
        issue(cpu_isa_pkg::mov, 3'd6, 3'd0, 8'd2);
        finish_test("6 unknown opcode and idle");
    endtask

    initial begin
        instr       = '0;
        instr_valid = 1'b0;
        wait (arst_n === 1'b1);
        reset_and_mov();
        load_all_regs();
        alu_ops_back_to_back();
        shift_amounts();
        zero_flag_rules();
        dropped_instrs();
        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 err_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // hang guard sized from the test lengths
    initial begin
        #((n_instr + n_overhead + 20) * clk_period_ns);
        $display("watchdog expired at %0t, the tests did not complete", $time);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
instr_decode.sv
reg_file.sv
alu.sv
result_writeback.sv
cpu_core.sv
tb_clock_gen.sv
tb_cpu_core.sv
